/* design/axi_pkg.sv */
// AXI read channel types for line fetches
// One line is fetched as a single incrementing burst of 32-bit beats

package axi_pkg;

	typedef logic [31:0] axi_addr_t;		// Byte address
	typedef logic [31:0] axi_data_t;		// One beat
	typedef logic [7:0] axi_len_t;			// Beats minus one

	localparam axi_len_t BURST_LEN = 8'd3;	// Four beats per line
	localparam int BYTES_PER_LINE = 16;

endpackage

/* design/l2_cache.sv */
// Load-only direct-mapped L2 cache, top level
// Pipeline is arbiter, tag/data lookup, response; misses go to the bus interface
// Hits answer 3 cycles after acceptance; misses answer after an AXI fetch and restart
// Responses have no back-pressure and may come back out of order
// MISS_QUEUE_DEPTH must be a power of two of at least 4
`timescale 1ns/10ps

module l2_cache import l2_cache_pkg::*, axi_pkg::*; #(
	parameter int SET_BITS = 6,
	parameter int MISS_QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic arst_n,

	input logic l2req_valid,
	input l2_req_t l2req,
	output logic l2req_ready,

	output logic l2rsp_valid,
	output l2_rsp_t l2rsp,

	output axi_addr_t axi_araddr,
	output axi_len_t axi_arlen,
	output logic axi_arvalid,
	input logic axi_arready,
	input logic axi_rvalid,
	input axi_data_t axi_rdata,
	output logic axi_rready,

	output logic pc_event_l2_hit,
	output logic pc_event_l2_miss
);

	arb_stage_t arb_stage;				// First pipeline stage
	lookup_t lookup;					// Tag result
	l2_req_t tag_req;					// Request beside the tag result
	l2_line_t line;						// Data result
	logic miss_valid;
	l2_req_t miss_req;
	logic miss_room;					// Queue has room for everything in flight
	logic restart_valid;
	logic restart_ready;
	l2_req_t restart_req;
	l2_line_t restart_line;

	l2_cache_arb arb (
		.clk(clk),
		.arst_n(arst_n),
		.l2req_valid(l2req_valid),
		.l2req(l2req),
		.restart_valid(restart_valid),
		.restart_req(restart_req),
		.restart_line(restart_line),
		.miss_room(miss_room),
		.l2req_ready(l2req_ready),
		.restart_ready(restart_ready),
		.arb_stage(arb_stage)
	);

	l2_cache_tag #(.SET_BITS(SET_BITS)) tag (
		.clk(clk),
		.arst_n(arst_n),
		.arb_stage(arb_stage),
		.lookup(lookup),
		.tag_req(tag_req)
	);

	l2_cache_data #(.SET_BITS(SET_BITS)) data (
		.clk(clk),
		.arb_stage(arb_stage),
		.line(line)
	);

	l2_cache_response response (
		.clk(clk),
		.arst_n(arst_n),
		.lookup(lookup),
		.tag_req(tag_req),
		.line(line),
		.l2rsp_valid(l2rsp_valid),
		.l2rsp(l2rsp),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.pc_event_l2_hit(pc_event_l2_hit),
		.pc_event_l2_miss(pc_event_l2_miss)
	);

	l2_cache_bus_interface #(.MISS_QUEUE_DEPTH(MISS_QUEUE_DEPTH)) bus_interface (
		.clk(clk),
		.arst_n(arst_n),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.restart_ready(restart_ready),
		.axi_arready(axi_arready),
		.axi_rvalid(axi_rvalid),
		.axi_rdata(axi_rdata),
		.miss_room(miss_room),
		.restart_valid(restart_valid),
		.restart_req(restart_req),
		.restart_line(restart_line),
		.axi_araddr(axi_araddr),
		.axi_arlen(axi_arlen),
		.axi_arvalid(axi_arvalid),
		.axi_rready(axi_rready)
	);

endmodule

/* design/l2_cache_arb.sv */
// Arbiter stage: a restarted fill always wins over a new request
// New requests are taken only while the miss queue has room reserved
// for every request that could still miss
`timescale 1ns/10ps

module l2_cache_arb import l2_cache_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic l2req_valid,
	input l2_req_t l2req,
	input logic restart_valid,
	input l2_req_t restart_req,
	input l2_line_t restart_line,
	input logic miss_room,
	output logic l2req_ready,
	output logic restart_ready,
	output arb_stage_t arb_stage
);

	logic new_accept;					// New request taken this cycle
	logic stage_valid;
	l2_req_t stage_req;
	logic stage_restarted;
	l2_line_t stage_fill;

	assign l2req_ready = miss_room && !restart_valid;	// Restart blocks new input
	assign new_accept = l2req_valid && l2req_ready;
	assign restart_ready = !new_accept;	// Free whenever no new request is taken

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= restart_valid || new_accept;
		end
	end

	always_ff @(posedge clk) begin
		if (restart_valid) begin
			stage_req <= restart_req;
			stage_restarted <= 1'b1;
		end else begin
			stage_req <= l2req;
			stage_restarted <= 1'b0;
		end
		stage_fill <= restart_line;		// Line fetched from memory, used on restart
	end

	assign arb_stage = '{
		valid: stage_valid,
		req: stage_req,
		restarted: stage_restarted,
		fill_line: stage_fill
	};

endmodule

/* design/l2_cache_bus_interface.sv */
// Miss queue and AXI read engine
// Each queued miss is fetched with one 4-beat burst, word 0 first, then
// offered back to the arbiter as a restart carrying the line
// miss_room stays high while 3 entries are free: 2 stages in flight plus one
// MISS_QUEUE_DEPTH must be a power of two of at least 4
// Only one fetch is outstanding at a time
`timescale 1ns/10ps

module l2_cache_bus_interface import l2_cache_pkg::*, axi_pkg::*; #(
	parameter int MISS_QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic arst_n,
	input logic miss_valid,
	input l2_req_t miss_req,
	input logic restart_ready,
	input logic axi_arready,
	input logic axi_rvalid,
	input axi_data_t axi_rdata,
	output logic miss_room,
	output logic restart_valid,
	output l2_req_t restart_req,
	output l2_line_t restart_line,
	output axi_addr_t axi_araddr,
	output axi_len_t axi_arlen,
	output logic axi_arvalid,
	output logic axi_rready
);

	localparam int PTR_BITS = $clog2(MISS_QUEUE_DEPTH);
	localparam int CNT_BITS = $clog2(MISS_QUEUE_DEPTH + 1);
	localparam int BEAT_BITS = $clog2(LINE_WORDS);

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_ADDR,
		BUS_DATA,
		BUS_RESTART
	} bus_state_t;

	bus_state_t state;
	l2_req_t queue [MISS_QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;
	logic [BEAT_BITS-1:0] beat_cnt;
	logic pop;
	logic beat;							// One R beat accepted
	l2_req_t cur_req;					// Request being fetched
	l2_line_t line_buf;

	assign pop = (state == BUS_IDLE) && (count != '0);
	assign beat = (state == BUS_DATA) && axi_rvalid;
	assign count_next = count + CNT_BITS'(miss_valid) - CNT_BITS'(pop);

	assign axi_arvalid = (state == BUS_ADDR);
	assign axi_rready = (state == BUS_DATA);
	assign axi_araddr = axi_addr_t'(cur_req.addr) * axi_addr_t'(BYTES_PER_LINE);
	assign axi_arlen = BURST_LEN;
	assign restart_valid = (state == BUS_RESTART);
	assign restart_req = cur_req;
	assign restart_line = line_buf;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= BUS_IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			beat_cnt <= '0;
			miss_room <= 1'b0;			// Low for the first cycle after reset
		end else begin
			count <= count_next;
			miss_room <= (int'(count_next) + 3 <= MISS_QUEUE_DEPTH);
			if (miss_valid)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case (state)
				BUS_IDLE: if (pop) state <= BUS_ADDR;
				BUS_ADDR: begin
					beat_cnt <= '0;
					if (axi_arready)
						state <= BUS_DATA;
				end
				BUS_DATA: if (beat) begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == BEAT_BITS'(LINE_WORDS - 1))
						state <= BUS_RESTART;	// Last beat in
				end
				BUS_RESTART: if (restart_ready) state <= BUS_IDLE;
				default: state <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (miss_valid)
			queue[wr_ptr] <= miss_req;
		if (pop)
			cur_req <= queue[rd_ptr];
		if (beat)
			line_buf <= {axi_rdata, line_buf[127:32]};	// Shift down, word 0 ends lowest
	end

endmodule

/* design/l2_cache_data.sv */
// Line data array, one line per set
// Read on every lookup; a restarted request writes its fill line
// and forwards it, so the response never reads stale data
`timescale 1ns/10ps

module l2_cache_data import l2_cache_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input arb_stage_t arb_stage,
	output l2_line_t line
);

	localparam int NUM_SETS = 2 ** SET_BITS;

	l2_line_t lines [NUM_SETS];
	logic [SET_BITS-1:0] set;
	logic fill;

	assign set = arb_stage.req.addr[SET_BITS-1:0];	// Same index as the tag array
	assign fill = arb_stage.valid && arb_stage.restarted;

	always_ff @(posedge clk) begin
		if (fill) begin
			lines[set] <= arb_stage.fill_line;
			line <= arb_stage.fill_line;	// Bypass the write
		end else begin
			line <= lines[set];
		end
	end

endmodule

/* design/l2_cache_pkg.sv */
// Shared types of the load-only L2 cache pipeline
// Tags hold the full line address, so no type here depends on SET_BITS
// A line is LINE_WORDS words of 32 bits, word 0 in the low bits

package l2_cache_pkg;

	localparam int LINE_WORDS = 4;			// 32-bit words per line

	typedef logic [25:0] l2_addr_t;			// Line address, byte address / 16
	typedef logic [127:0] l2_line_t;		// One full cache line

	typedef struct packed {
		logic [1:0] core;
		logic [1:0] unit;
		logic [1:0] strand;
	} requester_t;						// Who gets the response

	typedef struct packed {
		requester_t requester;
		l2_addr_t addr;
	} l2_req_t;

	// Idle marks an empty lookup stage
	typedef enum logic [1:0] {
		LOOKUP_IDLE,
		LOOKUP_HIT,
		LOOKUP_MISS,
		LOOKUP_FILL
	} lookup_t;

	typedef struct packed {
		logic valid;
		l2_req_t req;
		logic restarted;				// Reissued after a fetch
		l2_line_t fill_line;			// Only meaningful when restarted
	} arb_stage_t;

	typedef struct packed {
		requester_t requester;
		l2_addr_t addr;
		l2_line_t line;
	} l2_rsp_t;

endpackage

/* design/l2_cache_response.sv */
// Response stage: hits and fills are answered, misses go to the bus interface
// l2rsp_valid is a one-cycle pulse with no ready
// The miss handoff is taken straight from the lookup registers, so the
// queue sees a miss one cycle before its event pulses
`timescale 1ns/10ps

module l2_cache_response import l2_cache_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lookup_t lookup,
	input l2_req_t tag_req,
	input l2_line_t line,
	output logic l2rsp_valid,
	output l2_rsp_t l2rsp,
	output logic miss_valid,
	output l2_req_t miss_req,
	output logic pc_event_l2_hit,
	output logic pc_event_l2_miss
);

	logic answer;						// Hit or fill, line is good

	assign answer = (lookup == LOOKUP_HIT) || (lookup == LOOKUP_FILL);

	assign miss_valid = (lookup == LOOKUP_MISS);	// Room was reserved at accept
	assign miss_req = tag_req;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			l2rsp_valid <= 1'b0;
			pc_event_l2_hit <= 1'b0;
			pc_event_l2_miss <= 1'b0;
		end else begin
			l2rsp_valid <= answer;
			pc_event_l2_hit <= (lookup == LOOKUP_HIT);	// Fills do not count
			pc_event_l2_miss <= (lookup == LOOKUP_MISS);
		end
	end

	always_ff @(posedge clk) begin
		l2rsp.requester <= tag_req.requester;
		l2rsp.addr <= tag_req.addr;
		l2rsp.line <= line;
	end

endmodule

/* design/l2_cache_tag.sv */
// Tag and valid array of the direct-mapped cache
// The set is the low SET_BITS of the line address; the tag is the whole address
// A restarted request installs its tag, any other request is compared
// Results are registered, one cycle after the arbiter stage
`timescale 1ns/10ps

module l2_cache_tag import l2_cache_pkg::*; #(
	parameter int SET_BITS = 6
) (
	input logic clk,
	input logic arst_n,
	input arb_stage_t arb_stage,
	output lookup_t lookup,
	output l2_req_t tag_req
);

	localparam int NUM_SETS = 2 ** SET_BITS;

	l2_addr_t tags [NUM_SETS];			// Full line address per set
	logic [NUM_SETS-1:0] valid_bits;
	logic [SET_BITS-1:0] set;
	logic tag_match;

	assign set = arb_stage.req.addr[SET_BITS-1:0];
	assign tag_match = valid_bits[set] && (tags[set] == arb_stage.req.addr);

	// Valid bits and the registered lookup result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
			lookup <= LOOKUP_IDLE;
		end else if (!arb_stage.valid) begin
			lookup <= LOOKUP_IDLE;
		end else if (arb_stage.restarted) begin
			valid_bits[set] <= 1'b1;	// Line now present
			lookup <= LOOKUP_FILL;
		end else begin
			lookup <= tag_match ? LOOKUP_HIT : LOOKUP_MISS;
		end
	end

	always_ff @(posedge clk) begin
		if (arb_stage.valid && arb_stage.restarted)
			tags[set] <= arb_stage.req.addr;	// Overwrites any older line
		tag_req <= arb_stage.req;
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the L2 cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_l2_cache -f src.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation did not exit cleanly, see sim.log"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
echo "Simulation reported failure, see sim.log"
exit 1

/* src.f */
design/l2_cache_pkg.sv
design/axi_pkg.sv
design/l2_cache_arb.sv
design/l2_cache_tag.sv
design/l2_cache_data.sv
design/l2_cache_response.sv
design/l2_cache_bus_interface.sv
design/l2_cache.sv
tests/l2_cache_checker.sv
tests/tb_l2_cache.sv

/* tests/l2_cache_checker.sv */
// Watches the L2 cache ports and compares every response with a reference line
// Requesters must not be reused while still outstanding
// Memory rule: each 32-bit word is its byte address xor 32'hc0de0000
// timed_out rises once TIMEOUT_CYCLES clock edges have passed
`timescale 1ns/10ps

module l2_cache_checker import l2_cache_pkg::*, axi_pkg::*; #(
	parameter int TIMEOUT_CYCLES = 2000
) (
	input logic clk,
	input logic arst_n,
	input logic l2req_valid,
	input l2_req_t l2req,
	input logic l2req_ready,
	input logic l2rsp_valid,
	input l2_rsp_t l2rsp,
	input axi_addr_t axi_araddr,
	input axi_len_t axi_arlen,
	input logic axi_arvalid,
	input logic axi_arready,
	input logic pc_event_l2_hit,
	input logic pc_event_l2_miss,
	output logic timed_out
);

	int cycle = 0;
	int errors = 0;
	int err_mark = 0;					// Errors at test start
	int tests = 0;
	int failed = 0;
	int pending = 0;					// Requests awaiting a response
	int accepts = 0;
	int responses = 0;
	int hit_count = 0;
	int miss_count = 0;
	int bursts = 0;
	int stall_count = 0;				// Cycles with valid held, ready low
	int hit_mark = 0;
	int miss_mark = 0;
	int burst_mark = 0;
	int stall_mark = 0;
	logic [63:0] busy = '0;				// One bit per requester_t value
	l2_addr_t req_addr [64];
	int accept_cycle [64];

	assign timed_out = (cycle >= TIMEOUT_CYCLES);

	// Expected line, word 0 in the low bits
	function automatic l2_line_t ref_line(input l2_addr_t a);
		l2_line_t l;
		axi_addr_t byte_addr;
		l = '0;
		byte_addr = axi_addr_t'(a) * 32'd16;
		for (int w = 0; w < LINE_WORDS; w++)
			l[w*32 +: 32] = (byte_addr + axi_addr_t'(4 * w)) ^ 32'hc0de0000;
		return l;
	endfunction

	task automatic fail(input string what);
		$display("Failure at cycle %0d: %s", cycle, what);
		errors++;
	endtask

	task automatic value_error(input string sig, input logic [127:0] exp, input logic [127:0] got);
		$display("ERROR %s: expected %h, got %h (cycle %0d)", sig, exp, got, cycle);
		errors++;
	endtask

	task automatic check_response();
		logic [5:0] id;
		id = l2rsp.requester;
		responses++;
		if (!busy[id]) begin
			fail("response for a requester with no outstanding request");
		end else begin
			if (l2rsp.addr !== req_addr[id])
				value_error("l2rsp.addr", 128'(req_addr[id]), 128'(l2rsp.addr));
			else if (l2rsp.line !== ref_line(req_addr[id]))
				value_error("l2rsp.line", ref_line(req_addr[id]), l2rsp.line);
			if (pc_event_l2_hit && (cycle - accept_cycle[id] != 3))	// Hit latency fixed
				value_error("hit latency", 128'(3), 128'(cycle - accept_cycle[id]));
			busy[id] = 1'b0;
			pending--;
		end
	endtask

	task automatic check_burst();
		logic found;
		found = 1'b0;
		bursts++;
		if (axi_arlen !== 8'd3)				// Four beats per line
			value_error("axi_arlen", 128'(3), 128'(axi_arlen));
		for (int i = 0; i < 64; i++)
			if (busy[i] && axi_addr_t'({req_addr[i], 4'h0}) == axi_araddr)
				found = 1'b1;				// Line address times 16
		if (!found)
			fail($sformatf("axi_araddr %h matches no outstanding request", axi_araddr));
	endtask

	always @(posedge clk) begin : watch
		logic [5:0] id;
		cycle = cycle + 1;
		if (arst_n) begin
			if (l2req_valid && !l2req_ready)
				stall_count++;
			if (l2req_valid && l2req_ready) begin
				id = l2req.requester;
				if (busy[id])
					fail("requester reused while outstanding");
				busy[id] = 1'b1;
				req_addr[id] = l2req.addr;
				accept_cycle[id] = cycle;
				pending++;
				accepts++;
			end
			if (axi_arvalid && axi_arready)
				check_burst();
			if (pc_event_l2_hit)
				hit_count++;
			if (pc_event_l2_miss)
				miss_count++;
			if (l2rsp_valid)
				check_response();
		end
	end

	task automatic check_idle();
		if (l2rsp_valid !== 1'b0)
			value_error("l2rsp_valid", 128'(0), 128'(l2rsp_valid));
		if (axi_arvalid !== 1'b0)
			value_error("axi_arvalid", 128'(0), 128'(axi_arvalid));
		if (pc_event_l2_hit !== 1'b0)
			value_error("pc_event_l2_hit", 128'(0), 128'(pc_event_l2_hit));
		if (pc_event_l2_miss !== 1'b0)
			value_error("pc_event_l2_miss", 128'(0), 128'(pc_event_l2_miss));
	endtask

	task automatic check_ready_rises();
		int n;
		n = 0;
		while (!l2req_ready && n < 2) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!l2req_ready)
			fail("l2req_ready stayed low for 2 cycles after reset");
	endtask

	task automatic check_counts(input int exp_hits, input int exp_misses, input int exp_bursts);
		if (hit_count - hit_mark != exp_hits)
			value_error("pc_event_l2_hit count", 128'(exp_hits), 128'(hit_count - hit_mark));
		if (miss_count - miss_mark != exp_misses)
			value_error("pc_event_l2_miss count", 128'(exp_misses), 128'(miss_count - miss_mark));
		if (bursts - burst_mark != exp_bursts)
			value_error("axi burst count", 128'(exp_bursts), 128'(bursts - burst_mark));
	endtask

	task automatic check_stall();
		if (stall_count == stall_mark)
			fail("l2req_ready never fell while a request waited");
	endtask

	task automatic begin_test();
		err_mark = errors;
		hit_mark = hit_count;
		miss_mark = miss_count;
		burst_mark = bursts;
		stall_mark = stall_count;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != err_mark) begin
			failed++;
			$display("test %0d %s: FAILED with %0d errors", tests, name, errors - err_mark);
		end else begin
			$display("test %0d %s: ok", tests, name);
		end
	endtask

	task automatic report();
		if (pending != 0)
			fail($sformatf("%0d requests never got a response", pending));
		if (responses != accepts)
			fail("response count differs from accepted request count");
		$display("tests %0d, failed %0d, errors %0d, requests %0d, responses %0d",
			tests, failed, errors, accepts, responses);
	endtask

endmodule

/* tests/tb_l2_cache.sv */
// Testbench for the L2 cache: clock, reset, request driver and AXI memory model
// Inputs change 2 ns after the rising edge; the checker samples on the edge
// AXI delays come from an LFSR, longer while slow is set
`timescale 1ns/10ps

module tb_l2_cache import l2_cache_pkg::*, axi_pkg::*; ();

	localparam int NUM_REQUESTS = 44;	// Sum over all tests
	localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 40 + 200;

	logic clk = 1'b0;
	logic arst_n;
	logic l2req_valid;
	l2_req_t l2req;
	logic l2req_ready;
	logic l2rsp_valid;
	l2_rsp_t l2rsp;
	axi_addr_t axi_araddr;
	axi_len_t axi_arlen;
	logic axi_arvalid;
	logic axi_arready;
	logic axi_rvalid;
	axi_data_t axi_rdata;
	logic axi_rready;
	logic pc_event_l2_hit;
	logic pc_event_l2_miss;
	logic timed_out;
	logic slow;							// Stretch AXI delays
	logic [31:0] drv_lfsr;
	logic [31:0] mem_lfsr;

	always #20 clk = ~clk;

	l2_cache #(.SET_BITS(6), .MISS_QUEUE_DEPTH(4)) UUT (.*);

	l2_cache_checker #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) chk (.*);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] s, input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			s = lfsr_step(s);
			v = (v << 1) | int'(s[0]);	// One step per bit
		end
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic send(input logic [5:0] id, input l2_addr_t a);
		l2req_valid = 1'b1;
		l2req = '{requester: requester_t'(id), addr: a};
		while (!l2req_ready)				// Ready is stable until the edge
			wait_cycle();
		wait_cycle();
		l2req_valid = 1'b0;
	endtask

	task automatic drain();
		while (chk.pending != 0)
			wait_cycle();
	endtask

	initial begin : axi_memory
		int delay;
		axi_addr_t base;
		axi_arready = 1'b0;
		axi_rvalid = 1'b0;
		axi_rdata = '0;
		mem_lfsr = 32'h85d5;
		forever begin
			wait_cycle();
			if (axi_arvalid) begin
				take_bits(mem_lfsr, 2, delay);
				repeat (delay + (slow ? 3 : 0)) wait_cycle();
				axi_arready = 1'b1;
				base = axi_araddr;
				wait_cycle();				// AR handshake on this edge
				axi_arready = 1'b0;
				for (int beat = 0; beat < LINE_WORDS; beat++) begin
					take_bits(mem_lfsr, 2, delay);
					repeat (delay + (slow ? 3 : 0)) wait_cycle();
					axi_rvalid = 1'b1;
					axi_rdata = (base + axi_addr_t'(4 * beat)) ^ 32'hc0de0000;
					while (!axi_rready)		// Beat held until the cache takes it
						wait_cycle();
					wait_cycle();			// R handshake on this edge
					axi_rvalid = 1'b0;
				end
			end
		end
	end

	initial begin : stimulus
		int v;
		arst_n = 1'b0;
		l2req_valid = 1'b0;
		l2req = '0;
		slow = 1'b0;
		drv_lfsr = 32'h85d5;
		repeat (4) @(posedge clk);
		#2 arst_n = 1'b1;

		chk.begin_test();
		chk.check_idle();
		chk.check_ready_rises();
		chk.end_test("reset state");

		chk.begin_test();
		send(6'd1, 26'h0100);				// Cold line, set 0
		drain();
		chk.check_counts(0, 1, 1);
		chk.end_test("cold miss and fetch");

		chk.begin_test();
		send(6'd2, 26'h0100);
		drain();
		chk.check_counts(1, 0, 0);
		chk.end_test("hit on filled line");

		chk.begin_test();
		send(6'd3, 26'h0140);				// Same set, other line
		drain();
		send(6'd4, 26'h0100);				// Evicted, misses again
		drain();
		chk.check_counts(0, 2, 2);
		chk.end_test("set conflict");

		chk.begin_test();
		slow = 1'b1;
		for (int i = 0; i < 40; i++) begin
			take_bits(drv_lfsr, 5, v);
			send(6'(10 + i), 26'h0200 + l2_addr_t'(v));	// 32 lines, many repeats
		end
		drain();
		chk.check_stall();
		chk.end_test("random stream with back-pressure");

		chk.report();
		if (chk.errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (timed_out);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule
